/* src/safe_ctrl_pkg.sv */
// Safety-mode controller shared definitions
// Hart count, configuration codes and FSM state encodings

`default_nettype none

package safe_ctrl_pkg;

  //////////////////////////////////////////////////
  // Cluster and configuration
  //////////////////////////////////////////////////

  localparam int unsigned NHARTS = 3;

  localparam int unsigned CFG_W = 2;

  // Codes 10 and 11 are not supported and keep the selector idle
  localparam logic [CFG_W-1:0] CFG_SINGLE = 2'b00;
  localparam logic [CFG_W-1:0] CFG_TMR    = 2'b01;

  //////////////////////////////////////////////////
  // Mode selector states
  //////////////////////////////////////////////////

  localparam int unsigned MODE_W = 2;

  localparam logic [MODE_W-1:0] MODE_RESET  = 2'd0;
  localparam logic [MODE_W-1:0] MODE_IDLE   = 2'd1;
  localparam logic [MODE_W-1:0] MODE_SINGLE = 2'd2;
  localparam logic [MODE_W-1:0] MODE_TMR    = 2'd3;

  // Single-mode boot sequencer states
  localparam int unsigned SGL_W = 3;

  localparam logic [SGL_W-1:0] SGL_RESET    = 3'd0;
  localparam logic [SGL_W-1:0] SGL_IDLE     = 3'd1;
  localparam logic [SGL_W-1:0] SGL_START    = 3'd2;
  localparam logic [SGL_W-1:0] SGL_RUN      = 3'd3;
  localparam logic [SGL_W-1:0] SGL_SYNC_OFF = 3'd4;

  // Per-hart TMR sequencer states
  localparam int unsigned TMR_W = 3;

  localparam logic [TMR_W-1:0] TMR_RESET = 3'd0;
  localparam logic [TMR_W-1:0] TMR_IDLE  = 3'd1;
  localparam logic [TMR_W-1:0] TMR_START = 3'd2;
  localparam logic [TMR_W-1:0] TMR_BOOT  = 3'd3;
  localparam logic [TMR_W-1:0] TMR_SYNC  = 3'd4;

endpackage

`default_nettype wire

/* src/mode_select_fsm.sv */
// Operating mode selector
// Picks single or TMR mode on start, enables external debug while idle

`default_nettype none

module mode_select_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [safe_ctrl_pkg::CFG_W-1:0]   safe_config_i,
  input  logic                              single_idle_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  tmr_idle_i,
  output logic                              single_mode_o,
  output logic                              tmr_mode_o,
  output logic                              ext_debug_en_o
);

  logic [safe_ctrl_pkg::MODE_W-1:0] state_q;
  logic [safe_ctrl_pkg::MODE_W-1:0] state_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_ctrl_pkg::MODE_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      safe_ctrl_pkg::MODE_RESET:
      begin
        state_d = safe_ctrl_pkg::MODE_IDLE;
      end
      safe_ctrl_pkg::MODE_IDLE:
      begin
        // Unsupported codes fall through and stay idle
        if (start_i && safe_config_i == safe_ctrl_pkg::CFG_SINGLE)
          state_d = safe_ctrl_pkg::MODE_SINGLE;
        else if (start_i && safe_config_i == safe_ctrl_pkg::CFG_TMR)
          state_d = safe_ctrl_pkg::MODE_TMR;
      end
      safe_ctrl_pkg::MODE_SINGLE:
      begin
        if (!start_i && single_idle_i)
          state_d = safe_ctrl_pkg::MODE_IDLE;
      end
      safe_ctrl_pkg::MODE_TMR:
      begin
        // Leave only once every hart sequencer is back home
        if (!start_i && (&tmr_idle_i))
          state_d = safe_ctrl_pkg::MODE_IDLE;
      end
      default:
      begin
        state_d = safe_ctrl_pkg::MODE_IDLE;
      end
    endcase
  end

  // Moore outputs
  assign ext_debug_en_o = (state_q == safe_ctrl_pkg::MODE_IDLE);
  assign single_mode_o  = (state_q == safe_ctrl_pkg::MODE_SINGLE);
  assign tmr_mode_o     = (state_q == safe_ctrl_pkg::MODE_TMR);

  // Debug opens only while every sequencer is back in idle
  a_idle_with_sequencers: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ext_debug_en_o |-> (single_idle_i && (&tmr_idle_i))
  );

endmodule

`default_nettype wire

/* src/single_boot_fsm.sv */
// Single-mode boot sequencer
// Halts the master cores, lets them run, handles software and external stops

`default_nettype none

module single_boot_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              single_mode_i,
  input  logic                              start_i,
  input  logic                              end_sw_routine_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  master_core_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  halt_ack_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  hart_wfi_i,
  output logic [safe_ctrl_pkg::NHARTS-1:0]  halt_req_o,
  output logic                              single_idle_o
);

  logic [safe_ctrl_pkg::SGL_W-1:0] state_q;
  logic [safe_ctrl_pkg::SGL_W-1:0] state_d;

  logic all_wfi;
  logic no_wfi;
  logic no_ack;

  assign all_wfi = &hart_wfi_i;
  assign no_wfi  = ~|hart_wfi_i;
  assign no_ack  = ~|halt_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_ctrl_pkg::SGL_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      safe_ctrl_pkg::SGL_RESET:
      begin
        state_d = safe_ctrl_pkg::SGL_IDLE;
      end
      safe_ctrl_pkg::SGL_IDLE:
      begin
        if (single_mode_i && start_i && !end_sw_routine_i)
          state_d = safe_ctrl_pkg::SGL_START;
      end
      safe_ctrl_pkg::SGL_START:
      begin
        // Wait for every master to acknowledge its halt
        if (halt_ack_i == master_core_i)
          state_d = safe_ctrl_pkg::SGL_RUN;
      end
      safe_ctrl_pkg::SGL_RUN:
      begin
        if (end_sw_routine_i && all_wfi)
          state_d = safe_ctrl_pkg::SGL_IDLE;
        else if (!start_i && no_ack && !end_sw_routine_i)
          state_d = safe_ctrl_pkg::SGL_SYNC_OFF;
      end
      safe_ctrl_pkg::SGL_SYNC_OFF:
      begin
        // External stop completes once all harts are awake
        if (no_wfi)
          state_d = safe_ctrl_pkg::SGL_IDLE;
      end
      default:
      begin
        state_d = safe_ctrl_pkg::SGL_IDLE;
      end
    endcase
  end

  // Halt request held in START until the acknowledge lands
  assign halt_req_o    = (state_q == safe_ctrl_pkg::SGL_START) ? master_core_i : '0;
  assign single_idle_o = (state_q == safe_ctrl_pkg::SGL_IDLE);

  // Request never falls before every requested master acknowledged
  a_req_until_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(|halt_req_o) |-> ($past(halt_ack_i) == $past(halt_req_o))
  );

endmodule

`default_nettype wire

/* src/tmr_hart_fsm.sv */
// Per-hart TMR lockstep sequencer
// Halts one hart, boots it on the shared bus and holds the voter until sync ends

`default_nettype none

module tmr_hart_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              tmr_mode_i,
  input  logic                              start_i,
  input  logic                              end_sw_routine_i,
  input  logic                              halt_ack_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  hart_wfi_i,
  output logic                              halt_req_o,
  output logic                              boot_o,
  output logic                              single_bus_o,
  output logic                              voter_en_o,
  output logic                              hart_idle_o
);

  logic [safe_ctrl_pkg::TMR_W-1:0] state_q;
  logic [safe_ctrl_pkg::TMR_W-1:0] state_d;

  // Lockstep ends only when the whole cluster sleeps
  logic all_wfi;

  assign all_wfi = &hart_wfi_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_ctrl_pkg::TMR_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      safe_ctrl_pkg::TMR_RESET:
      begin
        state_d = safe_ctrl_pkg::TMR_IDLE;
      end
      safe_ctrl_pkg::TMR_IDLE:
      begin
        if (tmr_mode_i && start_i)
          state_d = safe_ctrl_pkg::TMR_START;
      end
      safe_ctrl_pkg::TMR_START:
      begin
        // Hart is halted
        if (halt_ack_i)
          state_d = safe_ctrl_pkg::TMR_BOOT;
      end
      safe_ctrl_pkg::TMR_BOOT:
      begin
        // Hart resumed from the boot address
        if (!halt_ack_i)
          state_d = safe_ctrl_pkg::TMR_SYNC;
      end
      safe_ctrl_pkg::TMR_SYNC:
      begin
        if (all_wfi && end_sw_routine_i)
          state_d = safe_ctrl_pkg::TMR_IDLE;
      end
      default:
      begin
        state_d = safe_ctrl_pkg::TMR_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Moore outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    halt_req_o   = 1'b0;
    boot_o       = 1'b0;
    single_bus_o = 1'b0;
    voter_en_o   = 1'b0;
    case (state_q)
      safe_ctrl_pkg::TMR_START:
      begin
        halt_req_o   = 1'b1;
        boot_o       = 1'b1;
        single_bus_o = 1'b1;
        voter_en_o   = 1'b1;
      end
      safe_ctrl_pkg::TMR_BOOT:
      begin
        boot_o       = 1'b1;
        single_bus_o = 1'b1;
        voter_en_o   = 1'b1;
      end
      safe_ctrl_pkg::TMR_SYNC:
      begin
        // Running in lockstep, boot flag already released
        single_bus_o = 1'b1;
        voter_en_o   = 1'b1;
      end
      default:
      begin
        halt_req_o = 1'b0;
      end
    endcase
  end

  assign hart_idle_o = (state_q == safe_ctrl_pkg::TMR_IDLE);

  // Voting stops only once software ended with the whole cluster asleep
  a_voter_until_sync_end: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(voter_en_o) |-> $past(all_wfi && end_sw_routine_i)
  );

endmodule

`default_nettype wire

/* src/safe_ctrl_top.sv */
// Safety-mode controller top level
// Mode selector, single-mode sequencer and one TMR sequencer per hart

`default_nettype none

module safe_ctrl_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic                              end_sw_routine_i,
  input  logic [safe_ctrl_pkg::CFG_W-1:0]   safe_config_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  master_core_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  halt_ack_i,
  input  logic [safe_ctrl_pkg::NHARTS-1:0]  hart_wfi_i,
  output logic [safe_ctrl_pkg::NHARTS-1:0]  halt_req_o,
  output logic                              single_bus_o,
  output logic                              tmr_voter_en_o,
  output logic                              start_boot_o,
  output logic                              ext_debug_en_o
);

  logic                             single_mode;
  logic                             tmr_mode;
  logic                             single_idle;
  logic [safe_ctrl_pkg::NHARTS-1:0] single_halt_req;

  // Per-hart TMR sequencer outputs
  logic [safe_ctrl_pkg::NHARTS-1:0] tmr_idle;
  logic [safe_ctrl_pkg::NHARTS-1:0] tmr_halt_req;
  logic [safe_ctrl_pkg::NHARTS-1:0] tmr_boot;
  logic [safe_ctrl_pkg::NHARTS-1:0] tmr_bus;
  logic [safe_ctrl_pkg::NHARTS-1:0] tmr_voter;

  mode_select_fsm mode_select_fsm_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .safe_config_i  (safe_config_i),
    .single_idle_i  (single_idle),
    .tmr_idle_i     (tmr_idle),
    .single_mode_o  (single_mode),
    .tmr_mode_o     (tmr_mode),
    .ext_debug_en_o (ext_debug_en_o)
  );

  single_boot_fsm single_boot_fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .single_mode_i    (single_mode),
    .start_i          (start_i),
    .end_sw_routine_i (end_sw_routine_i),
    .master_core_i    (master_core_i),
    .halt_ack_i       (halt_ack_i),
    .hart_wfi_i       (hart_wfi_i),
    .halt_req_o       (single_halt_req),
    .single_idle_o    (single_idle)
  );

  for (genvar i = 0; i < safe_ctrl_pkg::NHARTS; i++)
  begin : g_tmr_hart
    tmr_hart_fsm tmr_hart_fsm_i (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .tmr_mode_i       (tmr_mode),
      .start_i          (start_i),
      .end_sw_routine_i (end_sw_routine_i),
      .halt_ack_i       (halt_ack_i[i]),
      .hart_wfi_i       (hart_wfi_i),
      .halt_req_o       (tmr_halt_req[i]),
      .boot_o           (tmr_boot[i]),
      .single_bus_o     (tmr_bus[i]),
      .voter_en_o       (tmr_voter[i]),
      .hart_idle_o      (tmr_idle[i])
    );
  end

  //////////////////////////////////////////////////
  // Output merging
  //////////////////////////////////////////////////

  assign halt_req_o     = single_halt_req | tmr_halt_req;
  assign single_bus_o   = |tmr_bus;
  assign tmr_voter_en_o = |tmr_voter;
  assign start_boot_o   = single_mode | (|tmr_boot);

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset source
// Free-running clock, reset held low for the first two cycles

`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 10
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/safe_ctrl_checker.sv */
// Output checker for the safety-mode controller
// Compares sampled DUT outputs with expected levels and keeps the tallies

`default_nettype none

module safe_ctrl_checker (
  input logic [safe_ctrl_pkg::NHARTS-1:0] halt_req_i,
  input logic                             single_bus_i,
  input logic                             tmr_voter_en_i,
  input logic                             start_boot_i,
  input logic                             ext_debug_en_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned error_count = 0;
  int unsigned test_errors = 0;
  int unsigned tests_ok    = 0;
  int unsigned tests_bad   = 0;
  string       test_name   = "none";

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    test_errors++;
    error_count++;
  endtask

  //////////////////////////////////////////////////
  // Comparisons against the live DUT ports
  //////////////////////////////////////////////////

  task automatic compare_vec(input string port, input logic [safe_ctrl_pkg::NHARTS-1:0] exp,
                             input logic [safe_ctrl_pkg::NHARTS-1:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: %s expected %b actual %b", test_name, port, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic compare_bit(input string port, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: %s expected %b actual %b", test_name, port, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic check_halt_req(input logic [safe_ctrl_pkg::NHARTS-1:0] exp);
    compare_vec("halt_req_o", exp, halt_req_i);
  endtask

  task automatic check_bus(input logic exp);
    compare_bit("single_bus_o", exp, single_bus_i);
  endtask

  task automatic check_voter(input logic exp);
    compare_bit("tmr_voter_en_o", exp, tmr_voter_en_i);
  endtask

  task automatic check_boot(input logic exp);
    compare_bit("start_boot_o", exp, start_boot_i);
  endtask

  task automatic check_debug(input logic exp);
    compare_bit("ext_debug_en_o", exp, ext_debug_en_i);
  endtask

  // Selector idle, nothing halted, debug open
  task automatic check_idle();
    check_halt_req('0);
    check_bus(1'b0);
    check_voter(1'b0);
    check_boot(1'b0);
    check_debug(1'b1);
  endtask

  task automatic end_test();
    if (test_errors == 0)
    begin
      tests_ok++;
      $display("[%0t ns] %s: ok", $time, test_name);
    end
    else
    begin
      tests_bad++;
      $display("[%0t ns] %s: %0d mismatches", $time, test_name, test_errors);
    end
  endtask

  task automatic print_counts();
    $display("Tests run %0d, ok %0d, failed %0d, errors %0d",
             tests_ok + tests_bad, tests_ok, tests_bad, error_count);
  endtask

endmodule

`default_nettype wire

/* testbench/safe_ctrl_tb.sv */
// Testbench top for the safety-mode controller
// Runs a table of boot and stop scenarios against a simple core model

`default_nettype none

module safe_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD      = 10;
  localparam int unsigned CYCLES_PER_TEST = 200;
  localparam int unsigned WAIT_LIMIT      = 60;
  localparam int unsigned HOLD_CYCLES     = 6;
  localparam int unsigned SEED            = 14222;

  localparam int unsigned STOP_SW   = 0;
  localparam int unsigned STOP_EXT  = 1;
  localparam int unsigned STOP_NONE = 2;

  typedef struct {
    string                            name;
    logic [safe_ctrl_pkg::CFG_W-1:0]  cfg;
    logic [safe_ctrl_pkg::NHARTS-1:0] mask;
    int unsigned                      stop;
    logic [safe_ctrl_pkg::NHARTS-1:0] exp_halt;
    logic                             exp_bus;
    logic                             exp_voter;
  } test_row_t;

  test_row_t tests [$];

  logic                             clk;
  logic                             rst_n;
  logic                             start;
  logic                             end_sw;
  logic [safe_ctrl_pkg::CFG_W-1:0]  safe_config;
  logic [safe_ctrl_pkg::NHARTS-1:0] master_core;
  logic [safe_ctrl_pkg::NHARTS-1:0] halt_ack;
  logic [safe_ctrl_pkg::NHARTS-1:0] hart_wfi;
  logic [safe_ctrl_pkg::NHARTS-1:0] halt_req;
  logic                             single_bus;
  logic                             tmr_voter_en;
  logic                             start_boot;
  logic                             ext_debug_en;

  tb_clk_gen #(
    .PERIOD_NS (CLK_PERIOD)
  ) tb_clk_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  safe_ctrl_top safe_ctrl_top_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .start_i          (start),
    .end_sw_routine_i (end_sw),
    .safe_config_i    (safe_config),
    .master_core_i    (master_core),
    .halt_ack_i       (halt_ack),
    .hart_wfi_i       (hart_wfi),
    .halt_req_o       (halt_req),
    .single_bus_o     (single_bus),
    .tmr_voter_en_o   (tmr_voter_en),
    .start_boot_o     (start_boot),
    .ext_debug_en_o   (ext_debug_en)
  );

  safe_ctrl_checker chk_i (
    .halt_req_i     (halt_req),
    .single_bus_i   (single_bus),
    .tmr_voter_en_i (tmr_voter_en),
    .start_boot_i   (start_boot),
    .ext_debug_en_i (ext_debug_en)
  );

  //////////////////////////////////////////////////
  // Core model
  //////////////////////////////////////////////////

  // Acks a pending halt after a random delay, drops the ack with the request
  initial
  begin
    int ack_wait [safe_ctrl_pkg::NHARTS];
    halt_ack = '0;
    void'($urandom(SEED));
    for (int h = 0; h < safe_ctrl_pkg::NHARTS; h++)
    begin
      ack_wait[h] = -1;
    end
    forever
    begin
      @(negedge clk);
      for (int h = 0; h < safe_ctrl_pkg::NHARTS; h++)
      begin
        if (halt_req[h] && !halt_ack[h])
        begin
          if (ack_wait[h] < 0)
            ack_wait[h] = $urandom % 5;
          if (ack_wait[h] == 0)
          begin
            halt_ack[h] <= 1'b1;
            ack_wait[h] = -1;
          end
          else
          begin
            ack_wait[h]--;
          end
        end
        else if (!halt_req[h] && halt_ack[h])
        begin
          halt_ack[h] <= 1'b0;
        end
      end
    end
  end

  // Single mode holds the whole mask until every master acked, TMR drops bit by bit
  task automatic run_boot(input test_row_t row);
    logic [safe_ctrl_pkg::NHARTS-1:0] acked;
    logic [safe_ctrl_pkg::NHARTS-1:0] exp_req;
    logic                             seen_req;
    logic                             single;
    int unsigned                      cycles;
    acked    = '0;
    seen_req = 1'b0;
    cycles   = 0;
    single   = (row.cfg == safe_ctrl_pkg::CFG_SINGLE);
    while (!(seen_req && (acked & row.exp_halt) == row.exp_halt && halt_ack == '0))
    begin
      @(negedge clk);
      if (cycles == WAIT_LIMIT)
      begin
        chk_i.report_fault("halt handshake did not complete in time");
        return;
      end
      cycles++;
      acked = acked | halt_ack;
      if (halt_req != '0)
        seen_req = 1'b1;
      if (seen_req)
      begin
        if (single)
          exp_req = ((acked & row.exp_halt) == row.exp_halt) ? '0 : row.exp_halt;
        else
          exp_req = row.exp_halt & ~acked;
        chk_i.check_halt_req(exp_req);
        chk_i.check_bus(row.exp_bus);
        chk_i.check_voter(row.exp_voter);
      end
      if (single || halt_req != '0)
        chk_i.check_boot(1'b1);
    end
  endtask

  task automatic wait_debug_enable();
    int unsigned cycles;
    cycles = 0;
    while (!ext_debug_en)
    begin
      @(negedge clk);
      if (cycles == WAIT_LIMIT)
      begin
        chk_i.report_fault("controller did not return to idle");
        return;
      end
      cycles++;
    end
  endtask

  task automatic run_stop(input test_row_t row);
    start    = 1'b0;
    hart_wfi = '1;
    if (row.stop == STOP_SW)
    begin
      end_sw = 1'b1;
    end
    else
    begin
      repeat (HOLD_CYCLES)
      begin
        @(negedge clk);
        // Harts still asleep, sequencer must hold
        chk_i.check_debug(1'b0);
        chk_i.check_boot(1'b1);
      end
      hart_wfi = '0;
    end
    wait_debug_enable();
    chk_i.check_idle();
    end_sw   = 1'b0;
    hart_wfi = '0;
  endtask

  task automatic run_unsupported();
    repeat (HOLD_CYCLES)
    begin
      @(negedge clk);
      chk_i.check_idle();
    end
    start = 1'b0;
  endtask

  initial
  begin
    start       = 1'b0;
    end_sw      = 1'b0;
    safe_config = safe_ctrl_pkg::CFG_SINGLE;
    master_core = '0;
    hart_wfi    = '0;
    // name, config, master mask, stop kind, halt mask, bus, voter
    tests.push_back('{"single_sw_m001", 2'b00, 3'b001, STOP_SW, 3'b001, 1'b0, 1'b0});
    tests.push_back('{"single_sw_m111", 2'b00, 3'b111, STOP_SW, 3'b111, 1'b0, 1'b0});
    tests.push_back('{"single_ext_m010", 2'b00, 3'b010, STOP_EXT, 3'b010, 1'b0, 1'b0});
    tests.push_back('{"single_ext_m101", 2'b00, 3'b101, STOP_EXT, 3'b101, 1'b0, 1'b0});
    tests.push_back('{"tmr_sw_m001", 2'b01, 3'b001, STOP_SW, 3'b111, 1'b1, 1'b1});
    tests.push_back('{"tmr_sw_m110", 2'b01, 3'b110, STOP_SW, 3'b111, 1'b1, 1'b1});
    tests.push_back('{"cfg_10_idle", 2'b10, 3'b111, STOP_NONE, 3'b000, 1'b0, 1'b0});
    tests.push_back('{"cfg_11_idle", 2'b11, 3'b011, STOP_NONE, 3'b000, 1'b0, 1'b0});

    @(posedge rst_n);
    chk_i.begin_test("reset_values");
    chk_i.check_halt_req('0);
    chk_i.check_bus(1'b0);
    chk_i.check_voter(1'b0);
    chk_i.check_boot(1'b0);
    chk_i.check_debug(1'b0);
    @(negedge clk);
    chk_i.check_idle();
    chk_i.end_test();

    foreach (tests[i])
    begin
      chk_i.begin_test(tests[i].name);
      @(negedge clk);
      safe_config = tests[i].cfg;
      master_core = tests[i].mask;
      start       = 1'b1;
      if (tests[i].stop == STOP_NONE)
      begin
        run_unsupported();
      end
      else
      begin
        run_boot(tests[i]);
        run_stop(tests[i]);
      end
      chk_i.end_test();
    end

    @(negedge clk);
    chk_i.print_counts();
    if (chk_i.error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    @(posedge rst_n);
    #((tests.size() + 1) * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before the test table finished");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/safe_ctrl_pkg.sv
src/mode_select_fsm.sv
src/single_boot_fsm.sv
src/tmr_hart_fsm.sv
src/safe_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/safe_ctrl_checker.sv
testbench/safe_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the safety-mode controller testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= safe_ctrl_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
